//--- s16_tilemap_pkg.sv
// Raster constants and shared types for the tile layer subsystem
// Imported by the timer, register block, both layers, the mixer and the top level
package s16_tilemap_pkg;

    localparam int CNT_W    = 9;    // Raster counter and scroll width
    localparam int H_TOTAL  = 320;
    localparam int V_TOTAL  = 262;
    localparam int H_ACTIVE = 256;
    localparam int V_ACTIVE = 224;

    // Fetch window start to first visible pixel of a column group
    localparam int PIPE_DLY   = 16;
    localparam int FETCH_LEAD = 16;

    // Sync pulses, in raster counts
    localparam int HS_START = 288;
    localparam int HS_END   = 304;
    localparam int VS_START = 240;
    localparam int VS_END   = 243;

    localparam logic CHAR_BANK = 1'b1;  // Scroll layer sits in bank 0

    // Register index on cpu_addr[2:1]
    typedef enum logic [1:0] {
        REG_HSCR,
        REG_VSCR,
        REG_PAGE,
        REG_NONE
    } reg_sel_e;

    // Per-group fetch sequence of each layer
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_GFX,
        FETCH_DONE
    } fetch_state_e;

endpackage

//--- video_timer.sv
// Raster counter with blanking, sync and the per-group fetch schedule
// Layers only see fetch_start, fetch_x/y and load, never raster positions
`timescale 1ns/1ps

module video_timer(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pxl_cen,
    output logic [s16_tilemap_pkg::CNT_W-1:0] hdump,
    output logic [s16_tilemap_pkg::CNT_W-1:0] vdump,
    output logic                              preLHBL,
    output logic                              preLVBL,
    output logic                              HS,
    output logic                              VS,
    output logic                              vint,
    output logic                              line_start,
    output logic                              fetch_start,
    output logic                              load,
    output logic [7:0]                        fetch_x,
    output logic [7:0]                        fetch_y
);
    import s16_tilemap_pkg::*;

    logic [CNT_W-1:0] fetch_h;     // Column whose fetch window opens now
    logic [CNT_W-1:0] load_h;      // Column whose shifter loads now
    logic             active_line;
    logic             h_last;

    assign fetch_h     = hdump - CNT_W'(PIPE_DLY - FETCH_LEAD);
    assign load_h      = hdump - CNT_W'(PIPE_DLY - 1);
    assign active_line = vdump < V_ACTIVE;
    assign h_last      = hdump == H_TOTAL - 1;

    assign line_start = pxl_cen && h_last;
    assign preLHBL    = hdump >= PIPE_DLY && hdump < PIPE_DLY + H_ACTIVE;
    assign preLVBL    = active_line;
    assign HS         = hdump >= HS_START && hdump < HS_END;
    assign VS         = vdump >= VS_START && vdump < VS_END;
    assign vint       = vdump == V_ACTIVE;   // Whole first blank line
    assign load       = pxl_cen && active_line && load_h[2:0] == 3'd0 && load_h < H_ACTIVE;

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump       <= '0;
            vdump       <= '0;
            fetch_start <= 1'b0;
            fetch_x     <= '0;
            fetch_y     <= '0;
        end else begin
            fetch_start <= 1'b0;
            if (pxl_cen) begin
                if (h_last) begin
                    hdump <= '0;
                    vdump <= (vdump == V_TOTAL - 1) ? '0 : vdump + 1'b1;
                end else begin
                    hdump <= hdump + 1'b1;
                end
                // One fetch per 8-pixel group of a visible line
                if (active_line && fetch_h[2:0] == 3'd0 && fetch_h < H_ACTIVE) begin
                    fetch_start <= 1'b1;
                    fetch_x     <= fetch_h[7:0];
                    fetch_y     <= vdump[7:0];
                end
            end
        end
    end

endmodule

//--- tile_regs.sv
// Scroll and page registers written by the CPU
// Pending values become the working values at line start so a line never tears
`timescale 1ns/1ps

module tile_regs(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              regs_cs,
    input  logic                              we,
    input  logic [2:1]                        cpu_addr,
    input  logic [15:0]                       cpu_dout,
    input  logic [1:0]                        dsn,
    input  logic                              line_start,
    output logic [s16_tilemap_pkg::CNT_W-1:0] hscr,
    output logic [s16_tilemap_pkg::CNT_W-1:0] vscr,
    output logic [1:0]                        page
);
    import s16_tilemap_pkg::*;

    reg_sel_e   sel;
    logic [5:0] hscr_p;   // Whole tiles only
    logic [8:0] vscr_p;
    logic [1:0] page_p;
    logic [5:0] hscr_w;

    assign sel  = reg_sel_e'(cpu_addr);
    assign hscr = {hscr_w, 3'b000};

    always_ff @(posedge clk) begin
        if (reset) begin
            hscr_p <= '0;
            vscr_p <= '0;
            page_p <= '0;
            hscr_w <= '0;
            vscr   <= '0;
            page   <= '0;
        end else begin
            if (regs_cs && we) begin
                case (sel)
                    REG_HSCR: begin
                        if (!dsn[0]) hscr_p[4:0] <= cpu_dout[7:3];
                        if (!dsn[1]) hscr_p[5]   <= cpu_dout[8];
                    end
                    REG_VSCR: begin
                        if (!dsn[0]) vscr_p[7:0] <= cpu_dout[7:0];
                        if (!dsn[1]) vscr_p[8]   <= cpu_dout[8];
                    end
                    REG_PAGE: if (!dsn[0]) page_p <= cpu_dout[1:0];
                    default: ;    // REG_NONE has no storage
                endcase
            end
            if (line_start) begin
                hscr_w <= hscr_p;
                vscr   <= vscr_p;
                page   <= page_p;
            end
        end
    end

endmodule

//--- char_layer.sv
// Fixed character layer: CPU-visible map RAM, character ROM fetch, pixel shifter
// Map entry holds the code in bits 7:0 and the colour in bits 10:8
`timescale 1ns/1ps

module char_layer(
    input  logic        clk,
    input  logic        reset,
    input  logic        pxl_cen,
    input  logic        char_cs,
    input  logic        we,
    input  logic [11:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    input  logic        fetch_start,
    input  logic        load,
    input  logic [7:0]  fetch_x,
    input  logic [7:0]  fetch_y,
    input  logic        char_ok,
    input  logic [31:0] char_data,
    output logic [15:0] char_dout,
    output logic [10:0] char_addr,
    output logic [6:0]  pxl
);
    import s16_tilemap_pkg::*;

    logic [15:0]  ram [1024];
    logic [9:0]   cpu_idx;
    logic [10:0]  ram_q;          // Entry of the group being fetched
    fetch_state_e state;
    logic         skip;           // ok may still answer the old address
    logic         tag;            // Buffer slot of the fetch in flight
    logic         stale;          // Its load has already passed
    logic [31:0]  gfx_q;
    logic [2:0]   pal_q;
    logic [31:0]  buf_data [2];
    logic [2:0]   buf_pal  [2];
    logic [1:0]   buf_vld;
    logic         ld_ptr;
    logic [31:0]  shift;
    logic [2:0]   shift_pal;

    assign cpu_idx = cpu_addr[10:1];
    assign pxl     = {shift_pal, shift[31:28]};

    // Upper half of the CPU window is unmapped
    always_ff @(posedge clk) begin
        if (char_cs && we && !cpu_addr[11]) begin
            if (!dsn[0]) ram[cpu_idx][7:0]  <= cpu_dout[7:0];
            if (!dsn[1]) ram[cpu_idx][15:8] <= cpu_dout[15:8];
        end
        if (char_cs && !we) begin
            char_dout <= cpu_addr[11] ? 16'h0000 : ram[cpu_idx];
        end
        if (fetch_start) begin
            ram_q <= ram[{fetch_y[7:3], fetch_x[7:3]}][10:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            skip      <= 1'b0;
            tag       <= 1'b0;
            stale     <= 1'b0;
            buf_vld   <= '0;
            ld_ptr    <= 1'b0;
            shift     <= '0;
            shift_pal <= '0;
            char_addr <= '0;
        end else begin
            skip <= 1'b0;
            case (state)
                FETCH_IDLE: if (fetch_start) begin
                    tag   <= fetch_x[3];
                    stale <= 1'b0;
                    state <= FETCH_MAP;
                end
                FETCH_MAP: begin          // RAM entry is ready now
                    char_addr <= {ram_q[7:0], fetch_y[2:0]};
                    pal_q     <= ram_q[10:8];
                    skip      <= 1'b1;
                    state     <= FETCH_GFX;
                end
                FETCH_GFX: if (char_ok && !skip) begin
                    gfx_q <= char_data;
                    state <= FETCH_DONE;
                end
                FETCH_DONE: begin
                    if (!stale) begin
                        buf_data[tag] <= gfx_q;
                        buf_pal[tag]  <= pal_q;
                        buf_vld[tag]  <= 1'b1;
                    end
                    state <= FETCH_IDLE;
                end
            endcase
            if (load) begin               // Missing data shows as transparent
                ld_ptr          <= ~ld_ptr;
                buf_vld[ld_ptr] <= 1'b0;
                shift           <= buf_vld[ld_ptr] ? buf_data[ld_ptr] : '0;
                shift_pal       <= buf_vld[ld_ptr] ? buf_pal[ld_ptr] : '0;
                if (state != FETCH_IDLE && tag == ld_ptr) stale <= 1'b1;
            end else if (pxl_cen) begin
                shift <= {shift[27:0], 4'h0};
            end
            if (fetch_start) buf_vld[fetch_x[3]] <= 1'b0;
        end
    end

endmodule

//--- scroll_layer.sv
// Scrolling background layer with map and graphics both read from ROM
// Two fetch buffers cover the overlap of one group's fetch with the previous load
// Data not in place at load gives a transparent group and a bad pulse
`timescale 1ns/1ps

module scroll_layer(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pxl_cen,
    input  logic                              fetch_start,
    input  logic                              load,
    input  logic [7:0]                        fetch_x,
    input  logic [7:0]                        fetch_y,
    input  logic [s16_tilemap_pkg::CNT_W-1:0] hscr,
    input  logic [s16_tilemap_pkg::CNT_W-1:0] vscr,
    input  logic [1:0]                        page,
    input  logic                              map_ok,
    input  logic [15:0]                       map_data,
    input  logic                              scr_ok,
    input  logic [31:0]                       scr_data,
    output logic [13:0]                       map_addr,
    output logic [13:0]                       scr_addr,
    output logic [9:0]                        pxl,
    output logic                              bad
);
    import s16_tilemap_pkg::*;

    fetch_state_e     state;
    logic [5:0]       col_tile;   // Fine horizontal bits are always 0
    logic [CNT_W-1:0] row;
    logic [2:0]       row_l;
    logic             skip;
    logic             tag;
    logic             stale;
    logic [31:0]      gfx_q;
    logic [4:0]       pal_q;
    logic [31:0]      buf_data [2];
    logic [4:0]       buf_pal  [2];
    logic [1:0]       buf_vld;
    logic             ld_ptr;     // Loads alternate slots, 32 per line
    logic [31:0]      shift;
    logic [4:0]       shift_pal;

    assign col_tile = {1'b0, fetch_x[7:3]} + hscr[8:3];
    assign row      = {1'b0, fetch_y} + vscr;
    assign pxl      = {1'b0, shift_pal, shift[31:28]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            skip      <= 1'b0;
            tag       <= 1'b0;
            stale     <= 1'b0;
            buf_vld   <= '0;
            ld_ptr    <= 1'b0;
            bad       <= 1'b0;
            shift     <= '0;
            shift_pal <= '0;
            map_addr  <= '0;
            scr_addr  <= '0;
        end else begin
            skip <= 1'b0;
            bad  <= 1'b0;
            case (state)
                FETCH_IDLE: if (fetch_start) begin
                    map_addr <= {page, row[8:3], col_tile};
                    row_l    <= row[2:0];
                    tag      <= fetch_x[3];
                    stale    <= 1'b0;
                    skip     <= 1'b1;
                    state    <= FETCH_MAP;
                end
                FETCH_MAP: if (map_ok && !skip) begin
                    scr_addr <= {map_data[10:0], row_l};
                    pal_q    <= map_data[15:11];
                    skip     <= 1'b1;
                    state    <= FETCH_GFX;
                end
                FETCH_GFX: if (scr_ok && !skip) begin
                    gfx_q <= scr_data;
                    state <= FETCH_DONE;
                end
                FETCH_DONE: begin
                    if (!stale) begin
                        buf_data[tag] <= gfx_q;
                        buf_pal[tag]  <= pal_q;
                        buf_vld[tag]  <= 1'b1;
                    end
                    state <= FETCH_IDLE;
                end
            endcase
            if (load) begin
                ld_ptr          <= ~ld_ptr;
                buf_vld[ld_ptr] <= 1'b0;
                shift           <= buf_vld[ld_ptr] ? buf_data[ld_ptr] : '0;
                shift_pal       <= buf_vld[ld_ptr] ? buf_pal[ld_ptr] : '0;
                bad             <= !buf_vld[ld_ptr];
                // A fetch still running for this slot is now too late
                if (state != FETCH_IDLE && tag == ld_ptr) stale <= 1'b1;
            end else if (pxl_cen) begin
                shift <= {shift[27:0], 4'h0};
            end
            if (fetch_start) buf_vld[fetch_x[3]] <= 1'b0;
        end
    end

endmodule

//--- layer_mixer.sv
// Priority mixer: opaque character pixels over scroll pixels
// One registered palette address per pixel enable, 0 in blanking
`timescale 1ns/1ps

module layer_mixer(
    input  logic        clk,
    input  logic        reset,
    input  logic        pxl_cen,
    input  logic        preLHBL,
    input  logic        preLVBL,
    input  logic [1:0]  gfx_en,
    input  logic [6:0]  char_pxl,
    input  logic [9:0]  scr_pxl,
    output logic [10:0] pal_addr
);
    import s16_tilemap_pkg::*;

    logic char_opaque;
    logic scr_opaque;

    // Index 0 is transparent on both layers
    assign char_opaque = gfx_en[0] && char_pxl[3:0] != 4'd0;
    assign scr_opaque  = gfx_en[1] && scr_pxl[3:0] != 4'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            if (!preLHBL || !preLVBL) pal_addr <= '0;
            else if (char_opaque) pal_addr <= {CHAR_BANK, 3'b000, char_pxl};
            else if (scr_opaque) pal_addr <= {1'b0, scr_pxl};
            else pal_addr <= '0;
        end
    end

endmodule

//--- s16_tilemap.sv
// Tile layer subsystem top level: raster timer, scroll registers,
// character and scroll layers, and the priority mixer
`timescale 1ns/1ps

module s16_tilemap(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pxl_cen,
    input  logic                              char_cs,
    input  logic                              regs_cs,
    input  logic                              we,
    input  logic [11:1]                       cpu_addr,
    input  logic [15:0]                       cpu_dout,
    input  logic [1:0]                        dsn,
    input  logic [1:0]                        gfx_en,
    input  logic                              char_ok,
    input  logic [31:0]                       char_data,
    input  logic                              map_ok,
    input  logic [15:0]                       map_data,
    input  logic                              scr_ok,
    input  logic [31:0]                       scr_data,
    output logic [15:0]                       char_dout,
    output logic                              vint,
    output logic                              HS,
    output logic                              VS,
    output logic                              preLHBL,
    output logic                              preLVBL,
    output logic [s16_tilemap_pkg::CNT_W-1:0] hdump,
    output logic [s16_tilemap_pkg::CNT_W-1:0] vdump,
    output logic [10:0]                       char_addr,
    output logic [13:0]                       map_addr,
    output logic [13:0]                       scr_addr,
    output logic [10:0]                       pal_addr,
    output logic                              scr_bad
);
    import s16_tilemap_pkg::*;

    logic             line_start;
    logic             fetch_start;
    logic             load;
    logic [7:0]       fetch_x;
    logic [7:0]       fetch_y;
    logic [CNT_W-1:0] hscr;
    logic [CNT_W-1:0] vscr;
    logic [1:0]       page;
    logic [6:0]       char_pxl;
    logic [9:0]       scr_pxl;

    video_timer u_timer(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .pxl_cen     ( pxl_cen     ),
        .hdump       ( hdump       ),
        .vdump       ( vdump       ),
        .preLHBL     ( preLHBL     ),
        .preLVBL     ( preLVBL     ),
        .HS          ( HS          ),
        .VS          ( VS          ),
        .vint        ( vint        ),
        .line_start  ( line_start  ),
        .fetch_start ( fetch_start ),
        .load        ( load        ),
        .fetch_x     ( fetch_x     ),
        .fetch_y     ( fetch_y     )
    );

    tile_regs u_regs(
        .clk        ( clk           ),
        .reset      ( reset         ),
        .regs_cs    ( regs_cs       ),
        .we         ( we            ),
        .cpu_addr   ( cpu_addr[2:1] ),
        .cpu_dout   ( cpu_dout      ),
        .dsn        ( dsn           ),
        .line_start ( line_start    ),
        .hscr       ( hscr          ),
        .vscr       ( vscr          ),
        .page       ( page          )
    );

    char_layer u_char(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .pxl_cen     ( pxl_cen     ),
        .char_cs     ( char_cs     ),
        .we          ( we          ),
        .cpu_addr    ( cpu_addr    ),
        .cpu_dout    ( cpu_dout    ),
        .dsn         ( dsn         ),
        .fetch_start ( fetch_start ),
        .load        ( load        ),
        .fetch_x     ( fetch_x     ),
        .fetch_y     ( fetch_y     ),
        .char_ok     ( char_ok     ),
        .char_data   ( char_data   ),
        .char_dout   ( char_dout   ),
        .char_addr   ( char_addr   ),
        .pxl         ( char_pxl    )
    );

    scroll_layer u_scr(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .pxl_cen     ( pxl_cen     ),
        .fetch_start ( fetch_start ),
        .load        ( load        ),
        .fetch_x     ( fetch_x     ),
        .fetch_y     ( fetch_y     ),
        .hscr        ( hscr        ),
        .vscr        ( vscr        ),
        .page        ( page        ),
        .map_ok      ( map_ok      ),
        .map_data    ( map_data    ),
        .scr_ok      ( scr_ok      ),
        .scr_data    ( scr_data    ),
        .map_addr    ( map_addr    ),
        .scr_addr    ( scr_addr    ),
        .pxl         ( scr_pxl     ),
        .bad         ( scr_bad     )
    );

    layer_mixer u_mixer(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .preLHBL  ( preLHBL  ),
        .preLVBL  ( preLVBL  ),
        .gfx_en   ( gfx_en   ),
        .char_pxl ( char_pxl ),
        .scr_pxl  ( scr_pxl  ),
        .pal_addr ( pal_addr )
    );

endmodule

//--- tb_rom_model.sv
// ROM responder for the testbench, one per external ROM port
// An address change drops ok, then ok rises with data_in after a random 1 to 4 clocks
// With slow set the delay is forced to 40 clocks
`timescale 1ns/1ps

module tb_rom_model #(
    parameter int AW = 11,
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          slow,
    input  logic [AW-1:0] addr,
    input  logic [DW-1:0] data_in,   // Contents at the current address
    output logic          ok,
    output logic [DW-1:0] data
);

    logic [AW-1:0] last;
    logic [5:0]    cnt;

    always @(posedge clk) begin
        if (reset) begin
            last <= '0;
            cnt  <= 6'd1;
            ok   <= 1'b0;
            data <= '0;
        end else if (addr != last) begin
            last <= addr;
            ok   <= 1'b0;
            cnt  <= slow ? 6'd40 : 6'(1 + $urandom % 4);
        end else if (!ok) begin
            if (cnt <= 6'd1) begin
                ok   <= 1'b1;
                data <= data_in;
            end else begin
                cnt <= cnt - 6'd1;
            end
        end
    end

endmodule

//--- tb_s16_tilemap.sv
// Testbench for the tile layer subsystem
// Reference pixel model built from the ROM functions and a copy of the character RAM
// Concurrent assertions check raster timing and every pixel while checks are on
`timescale 1ns/1ps

module tb_s16_tilemap;
    import s16_tilemap_pkg::*;

    localparam logic [31:0] CHAR_SALT  = 32'h1b87_3593;
    localparam logic [31:0] MAP_SALT   = 32'h5c4b_2f01;
    localparam logic [31:0] SCR_SALT   = 32'hcc9e_2d51;
    localparam int          WAIT_LIMIT = 400000;   // Clocks, a bit over two frames

    logic        clk, reset, pxl_cen, char_cs, regs_cs, we;
    logic [11:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn, gfx_en;
    logic        char_ok, map_ok, scr_ok;
    logic [31:0] char_data, scr_data;
    logic [15:0] map_data;
    logic [15:0] char_dout;
    logic        vint, HS, VS, preLHBL, preLVBL, scr_bad;
    logic [8:0]  hdump, vdump;
    logic [10:0] char_addr, pal_addr;
    logic [13:0] map_addr, scr_addr;

    logic [31:0] char_rom_d, scr_rom_d;
    logic [15:0] map_rom_d;
    logic        slow_scr;    // Scroll graphics ROM answers late
    logic        chk_pix;
    logic [15:0] cram [1024]; // Copy of the character RAM
    logic [5:0]  hs_p, hs_w;  // Pending and working scroll values
    logic [8:0]  vs_p, vs_w;
    logic [1:0]  pg_p, pg_w;
    logic [8:0]  ref_h, ref_v;
    logic [10:0] exp_pal;
    int          bad_count;

    s16_tilemap s16_tilemap_inst(.*);

    tb_rom_model #(.AW(11), .DW(32)) char_rom(.clk(clk), .reset(reset), .slow(1'b0),
        .addr(char_addr), .data_in(char_rom_d), .ok(char_ok), .data(char_data));
    tb_rom_model #(.AW(14), .DW(16)) map_rom(.clk(clk), .reset(reset), .slow(1'b0),
        .addr(map_addr), .data_in(map_rom_d), .ok(map_ok), .data(map_data));
    tb_rom_model #(.AW(14), .DW(32)) scr_rom(.clk(clk), .reset(reset), .slow(slow_scr),
        .addr(scr_addr), .data_in(scr_rom_d), .ok(scr_ok), .data(scr_data));

    function automatic logic [31:0] rom_hash(input logic [31:0] a, input logic [31:0] salt);
        logic [31:0] h;
        h = (a ^ salt) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        return h ^ (h >> 13);
    endfunction

    // About a third of the nibbles come out 0, so transparency is common
    function automatic logic [31:0] gfx_word(input logic [31:0] a, input logic [31:0] salt);
        logic [31:0] h;
        h = rom_hash(a, salt);
        return h & {h[7:0], h[31:8]};
    endfunction

    // Code low bits follow the tile column, so each new tile moves scr_addr
    function automatic logic [15:0] map_word(input logic [31:0] a, input logic [31:0] salt);
        logic [31:0] h;
        h = rom_hash(a, salt);
        return {h[15:6], a[5:0]};
    endfunction

    function automatic logic [3:0] pixel_of(input logic [31:0] d, input logic [2:0] px);
        logic [31:0] s;
        s = d << {px, 2'b00};   // Leftmost pixel in the top nibble
        return s[31:28];
    endfunction

    function automatic logic [10:0] ref_pixel(input logic [8:0] h, input logic [8:0] v);
        logic [7:0]  x, y;
        logic [15:0] entry, md;
        logic [31:0] cd, sd;
        logic [5:0]  colt;
        logic [8:0]  rowv;
        logic [3:0]  cidx, sidx;
        if (h < 9'd16 || h >= 9'd272 || v >= 9'd224) return '0;
        x     = 8'(h - 9'd16);
        y     = v[7:0];
        entry = cram[{y[7:3], x[7:3]}];
        cd    = gfx_word({21'd0, entry[7:0], y[2:0]}, CHAR_SALT);
        cidx  = pixel_of(cd, x[2:0]);
        colt  = {1'b0, x[7:3]} + hs_w;
        rowv  = {1'b0, y} + vs_w;
        md    = map_word({18'd0, pg_w, rowv[8:3], colt}, MAP_SALT);
        sd    = gfx_word({18'd0, md[10:0], rowv[2:0]}, SCR_SALT);
        sidx  = slow_scr ? 4'd0 : pixel_of(sd, x[2:0]);
        if (gfx_en[0] && cidx != 4'd0) return {1'b1, 3'b000, entry[10:8], cidx};
        if (gfx_en[1] && sidx != 4'd0) return {2'b00, md[15:11], sidx};
        return '0;
    endfunction

    assign char_rom_d = gfx_word({21'd0, char_addr}, CHAR_SALT);
    assign map_rom_d  = map_word({18'd0, map_addr}, MAP_SALT);
    assign scr_rom_d  = gfx_word({18'd0, scr_addr}, SCR_SALT);

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
        $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expv, actv);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic expect_val(input string name, input logic [31:0] expv, input logic [31:0] actv);
        assert (expv == actv) else mismatch(name, expv, actv);
    endtask

    // Raster reference, expected pixel and line-start copy of the scroll values
    always @(posedge clk) begin
        if (reset) begin
            ref_h   <= '0;
            ref_v   <= '0;
            exp_pal <= '0;
            hs_w    <= '0;
            vs_w    <= '0;
            pg_w    <= '0;
        end else if (pxl_cen) begin
            exp_pal <= ref_pixel(ref_h, ref_v);
            if (ref_h == 9'd319) begin
                ref_h <= '0;
                ref_v <= (ref_v == 9'd261) ? 9'd0 : ref_v + 9'd1;
                hs_w  <= hs_p;
                vs_w  <= vs_p;
                pg_w  <= pg_p;
            end else begin
                ref_h <= ref_h + 9'd1;
            end
        end
        if (scr_bad) bad_count++;
    end

    assert property (@(posedge clk) disable iff (reset) hdump == ref_h)
        else mismatch("hdump", $sampled(ref_h), $sampled(hdump));
    assert property (@(posedge clk) disable iff (reset) vdump == ref_v)
        else mismatch("vdump", $sampled(ref_v), $sampled(vdump));
    assert property (@(posedge clk) disable iff (reset)
        preLHBL == (ref_h >= 9'd16 && ref_h < 9'd272))
        else mismatch("preLHBL", !$sampled(preLHBL), $sampled(preLHBL));
    assert property (@(posedge clk) disable iff (reset) preLVBL == (ref_v < 9'd224))
        else mismatch("preLVBL", !$sampled(preLVBL), $sampled(preLVBL));
    assert property (@(posedge clk) disable iff (reset) vint == (ref_v == 9'd224))
        else mismatch("vint", !$sampled(vint), $sampled(vint));
    assert property (@(posedge clk) disable iff (reset)
        HS == (ref_h >= 9'(HS_START) && ref_h < 9'(HS_END)))
        else mismatch("HS", !$sampled(HS), $sampled(HS));
    assert property (@(posedge clk) disable iff (reset)
        VS == (ref_v >= 9'(VS_START) && ref_v < 9'(VS_END)))
        else mismatch("VS", !$sampled(VS), $sampled(VS));
    assert property (@(posedge clk) disable iff (reset) pxl_cen && chk_pix |-> pal_addr == exp_pal)
        else mismatch("pal_addr", $sampled(exp_pal), $sampled(pal_addr));
    assert property (@(posedge clk) disable iff (reset) scr_bad |-> slow_scr)
        else mismatch("scr_bad", 0, 1);

    task automatic wait_raster(input int v, input int h, input string what);
        int n;
        n = 0;
        while (!(vdump == 9'(v) && hdump == 9'(h))) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) abort({"Timeout while waiting for ", what});
        end
    endtask

    task automatic write_char(input int idx, input logic [15:0] d, input logic [1:0] be_n);
        char_cs  = 1'b1;
        we       = 1'b1;
        cpu_addr = {1'b0, 10'(idx)};
        cpu_dout = d;
        dsn      = be_n;
        @(posedge clk);
        #1;
        char_cs = 1'b0;
        we      = 1'b0;
        dsn     = 2'b11;
        if (!be_n[0]) cram[idx][7:0] = d[7:0];
        if (!be_n[1]) cram[idx][15:8] = d[15:8];
    endtask

    task automatic read_char(input int idx);
        char_cs  = 1'b1;
        we       = 1'b0;
        cpu_addr = {1'b0, 10'(idx)};
        @(posedge clk);
        #1;
        char_cs = 1'b0;
        expect_val("char_dout", cram[idx], char_dout);
    endtask

    task automatic write_reg(input logic [1:0] sel, input logic [15:0] d);
        regs_cs  = 1'b1;
        we       = 1'b1;
        cpu_addr = {9'd0, sel};
        cpu_dout = d;
        dsn      = 2'b00;
        @(posedge clk);
        #1;
        regs_cs = 1'b0;
        we      = 1'b0;
        dsn     = 2'b11;
        case (sel)
            2'd0: hs_p = d[8:3];
            2'd1: vs_p = d[8:0];
            2'd2: pg_p = d[1:0];
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            pxl_cen = ~pxl_cen;
        end
    end

    initial begin
        void'($urandom(6));
        reset     = 1'b1;
        char_cs   = 1'b0;
        regs_cs   = 1'b0;
        we        = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        dsn       = 2'b11;
        gfx_en    = 2'b00;
        slow_scr  = 1'b0;
        chk_pix   = 1'b0;
        hs_p      = '0;
        vs_p      = '0;
        pg_p      = '0;
        bad_count = 0;
        repeat (2) @(posedge clk);
        #1;
        expect_val("hdump", 0, hdump);
        expect_val("vdump", 0, vdump);
        expect_val("vint", 0, vint);
        expect_val("pal_addr", 0, pal_addr);
        expect_val("scr_bad", 0, scr_bad);
        expect_val("line_start", 0, s16_tilemap_inst.u_timer.line_start);
        expect_val("fetch_start", 0, s16_tilemap_inst.u_timer.fetch_start);
        expect_val("load", 0, s16_tilemap_inst.u_timer.load);
        reset = 1'b0;

        // Fill the whole map, then byte writes, then readback
        for (int i = 0; i < 1024; i++) write_char(i, 16'($urandom), 2'b00);
        for (int i = 0; i < 16; i++) begin
            write_char(int'($urandom % 1024), 16'($urandom), ($urandom % 2) ? 2'b01 : 2'b10);
        end
        for (int i = 0; i < 80; i++) read_char(int'($urandom % 1024));

        gfx_en = 2'b01;
        wait_raster(0, 0, "frame start");
        chk_pix = 1'b1;
        wait_raster(230, 0, "vertical blank");

        // Scroll setup in vertical blank, then both layers
        write_reg(2'd0, 16'h0048);
        write_reg(2'd1, 16'h0135);
        write_reg(2'd2, 16'h0002);
        gfx_en = 2'b11;
        wait_raster(0, 0, "frame start");
        wait_raster(230, 0, "vertical blank");

        // Mid-line write shows from the next line on
        wait_raster(100, 150, "line 100");
        write_reg(2'd0, 16'h00f0);
        write_reg(2'd1, 16'h0021);
        wait_raster(230, 0, "vertical blank");

        slow_scr = 1'b1;
        wait_raster(0, 0, "frame start");
        wait_raster(230, 0, "vertical blank");

        if (bad_count == 0) begin
            $display("scr_bad never pulsed with the slow scroll ROM");
            $display("Done: errors found");
            $fatal(1);
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- s16_tilemap.f
s16_tilemap_pkg.sv
video_timer.sv
tile_regs.sv
char_layer.sv
scroll_layer.sv
layer_mixer.sv
s16_tilemap.sv
tb_rom_model.sv
tb_s16_tilemap.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_s16_tilemap -f s16_tilemap.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0
